/* common/noise_defs.svh */
`ifndef NOISE_DEFS_SVH
`define NOISE_DEFS_SVH

// phi cycles in one frame-sequencer step
// kept short so that a full 8-step frame fits a brief simulation
`define NOISE_FS_STEP_CYCLES 32

// phi cycles per unit of the polynomial period
`define NOISE_DIV_SCALE 1

`endif

/* common/noise_pkg.sv */
`default_nettype none

package noise_pkg;

	typedef enum logic [1:0] {
		REG_LENGTH   = 2'd0,
		REG_ENVELOPE = 2'd1,
		REG_POLY     = 2'd2,
		REG_CONTROL  = 2'd3
	} noise_reg_e;

	typedef enum logic {
		ENV_DOWN = 1'b0,
		ENV_UP   = 1'b1
	} env_dir_e;

	typedef enum logic {
		LFSR_15 = 1'b0,
		LFSR_7  = 1'b1
	} lfsr_width_e;

	// same bit order as the envelope register byte
	typedef struct packed {
		logic [3:0] init_vol;
		env_dir_e   dir;
		logic [2:0] period;
	} envelope_cfg_t;

	// same bit order as the polynomial register byte
	typedef struct packed {
		logic [3:0]  shift;
		lfsr_width_e width;
		logic [2:0]  div_code;
	} poly_cfg_t;

endpackage

`default_nettype wire

/* common/noise_cfg_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface noise_cfg_if;

	noise_pkg::envelope_cfg_t env;
	noise_pkg::poly_cfg_t     poly;
	logic [5:0]               length_init;
	logic                     length_load; // one cycle, length write
	logic                     length_en;
	logic                     restart;     // one cycle, after trigger write

	modport regs (
		output env,
		output poly,
		output length_init,
		output length_load,
		output length_en,
		output restart
	);

	modport core (
		input env,
		input poly,
		input length_init,
		input length_load,
		input length_en,
		input restart
	);

endinterface

`default_nettype wire

/* design/noise_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module noise_regs (
	input  logic                  phi,
	input  logic                  rst,
	input  logic                  wr_en,
	input  logic                  rd_en,
	input  noise_pkg::noise_reg_e addr,
	input  logic [7:0]            wdata,
	output logic [7:0]            rdata,
	noise_cfg_if.regs             cfg
);

	noise_pkg::envelope_cfg_t env_q;
	noise_pkg::poly_cfg_t     poly_q;
	logic                     length_en_q;
	logic                     restart_q;
	logic                     wr_length;
	logic                     wr_env;
	logic                     wr_poly;
	logic                     wr_ctrl;

	assign wr_length = wr_en && (addr == noise_pkg::REG_LENGTH);
	assign wr_env    = wr_en && (addr == noise_pkg::REG_ENVELOPE);
	assign wr_poly   = wr_en && (addr == noise_pkg::REG_POLY);
	assign wr_ctrl   = wr_en && (addr == noise_pkg::REG_CONTROL);

	always_ff @(posedge phi) begin
		if (rst) begin
			env_q       <= '0;
			poly_q      <= '0;
			length_en_q <= 1'b0;
			restart_q   <= 1'b0;
		end else begin
			if (wr_env)
				env_q <= noise_pkg::envelope_cfg_t'(wdata);
			if (wr_poly)
				poly_q <= noise_pkg::poly_cfg_t'(wdata);
			if (wr_ctrl)
				length_en_q <= wdata[6];
			restart_q <= wr_ctrl && wdata[7]; // trigger bit
		end
	end

	// counter loads straight from the bus in the write cycle
	assign cfg.length_init = wdata[5:0];
	assign cfg.length_load = wr_length;
	assign cfg.length_en   = length_en_q;
	assign cfg.env         = env_q;
	assign cfg.poly        = poly_q;
	assign cfg.restart     = restart_q;

	// write-only bits read as ones
	always_comb begin
		rdata = 8'hFF;
		if (rd_en) begin
			case (addr)
				noise_pkg::REG_LENGTH:   rdata = 8'hFF;
				noise_pkg::REG_ENVELOPE: rdata = env_q;
				noise_pkg::REG_POLY:     rdata = poly_q;
				noise_pkg::REG_CONTROL:  rdata = {1'b1, length_en_q, 6'h3F};
				default:                 rdata = 8'hFF;
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/frame_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "noise_defs.svh"

module frame_sequencer (
	input  logic phi,
	input  logic rst,
	output logic length_tick,
	output logic env_tick
);

	localparam int CNT_W = $clog2(`NOISE_FS_STEP_CYCLES);

	logic [CNT_W-1:0] cyc_q;
	logic [2:0]       step_q;
	logic             step_end;
	logic             pre_end;

	assign step_end = (cyc_q == CNT_W'(`NOISE_FS_STEP_CYCLES - 1));
	// decode one cycle early so the registered tick lands on the step's last cycle
	assign pre_end  = (cyc_q == CNT_W'(`NOISE_FS_STEP_CYCLES - 2));

	always_ff @(posedge phi) begin
		if (rst) begin
			cyc_q       <= '0;
			step_q      <= 3'd0;
			length_tick <= 1'b0;
			env_tick    <= 1'b0;
		end else begin
			if (step_end) begin
				cyc_q  <= '0;
				step_q <= step_q + 3'd1;
			end else begin
				cyc_q <= cyc_q + CNT_W'(1);
			end
			length_tick <= pre_end && !step_q[0]; // steps 0 2 4 6
			env_tick    <= pre_end && (step_q == 3'd7);
		end
	end

endmodule

`default_nettype wire

/* design/noise_length.sv */
`timescale 1ns/100ps
`default_nettype none

module noise_length (
	input  logic      phi,
	input  logic      rst,
	noise_cfg_if.core cfg,
	input  logic      length_tick,
	output logic      length_expire
);

	logic [5:0] count_q;
	logic       count_en;

	assign count_en = length_tick && cfg.length_en;

	// wrap from 63 ends the note, a load in the same cycle takes priority
	assign length_expire = count_en && !cfg.length_load && (count_q == 6'd63);

	// restart leaves the count alone, so an expired counter gives 64 ticks
	always_ff @(posedge phi) begin
		if (rst) begin
			count_q <= 6'd0;
		end else if (cfg.length_load) begin
			count_q <= cfg.length_init;
		end else if (count_en) begin
			count_q <= count_q + 6'd1; // wraps to 0
		end
	end

endmodule

`default_nettype wire

/* design/noise_lfsr.sv */
`timescale 1ns/100ps
`default_nettype none

`include "noise_defs.svh"

module noise_lfsr (
	input  logic      phi,
	input  logic      rst,
	noise_cfg_if.core cfg,
	output logic      noise_bit
);

	localparam int DIV_W = 24; // 112 << 13 with room for the scale

	logic [6:0]       base;
	logic [DIV_W-1:0] period;
	logic [DIV_W-1:0] div_q;
	logic             div_zero;
	logic             run;
	logic             fb;
	logic [14:0]      lfsr_q;
	logic [14:0]      lfsr_next;

	always_comb begin
		if (cfg.poly.div_code == 3'd0)
			base = 7'd8;
		else
			base = {cfg.poly.div_code, 4'd0};
		period = (DIV_W'(base) << cfg.poly.shift) * DIV_W'(`NOISE_DIV_SCALE);
	end

	assign run      = (cfg.poly.shift < 4'd14); // shifts 14 and 15 freeze the noise
	assign div_zero = (div_q == '0);

	assign fb = lfsr_q[0] ^ lfsr_q[1];

	always_comb begin
		lfsr_next = {fb, lfsr_q[14:1]};
		if (cfg.poly.width == noise_pkg::LFSR_7)
			lfsr_next[6] = fb; // short loop
	end

	always_ff @(posedge phi) begin
		if (rst) begin
			div_q  <= '0;
			lfsr_q <= '1;
		end else if (cfg.restart) begin
			div_q  <= period - DIV_W'(1);
			lfsr_q <= '1;
		end else if (run) begin
			if (div_zero) begin
				div_q  <= period - DIV_W'(1);
				lfsr_q <= lfsr_next;
			end else begin
				div_q <= div_q - DIV_W'(1);
			end
		end
	end

	assign noise_bit = lfsr_q[0];

endmodule

`default_nettype wire

/* design/noise_envelope.sv */
`timescale 1ns/100ps
`default_nettype none

module noise_envelope (
	input  logic       phi,
	input  logic       rst,
	noise_cfg_if.core  cfg,
	input  logic       env_tick,
	output logic [3:0] volume
);

	logic [2:0] period_q;
	logic [3:0] vol_q;
	logic       env_run;
	logic       step;
	logic       at_limit;

	assign env_run = (cfg.env.period != 3'd0); // period 0 holds the volume

	// a count of 0 left from restart also counts as expiry
	assign step = env_tick && env_run && (period_q <= 3'd1);

	always_comb begin
		if (cfg.env.dir == noise_pkg::ENV_UP)
			at_limit = (vol_q == 4'd15);
		else
			at_limit = (vol_q == 4'd0);
	end

	always_ff @(posedge phi) begin
		if (rst) begin
			period_q <= 3'd0;
			vol_q    <= 4'd0;
		end else if (cfg.restart) begin
			period_q <= cfg.env.period;
			vol_q    <= cfg.env.init_vol;
		end else if (step) begin
			period_q <= cfg.env.period;
			if (!at_limit) begin
				if (cfg.env.dir == noise_pkg::ENV_UP)
					vol_q <= vol_q + 4'd1;
				else
					vol_q <= vol_q - 4'd1;
			end
		end else if (env_tick && env_run) begin
			period_q <= period_q - 3'd1;
		end
	end

	assign volume = vol_q;

endmodule

`default_nettype wire

/* design/noise_channel.sv */
`timescale 1ns/100ps
`default_nettype none

module noise_channel (
	input  logic       phi,
	input  logic       rst,
	input  logic       wr_en,
	input  logic       rd_en,
	input  logic [1:0] addr,
	input  logic [7:0] wdata,
	output logic [7:0] rdata,
	output logic       ch4_active,
	output logic       dac_en,
	output logic [3:0] ch4_out
);

	noise_cfg_if cfg ();

	logic       length_tick;
	logic       env_tick;
	logic       length_expire;
	logic       noise_bit;
	logic [3:0] volume;
	logic       active_q;

	noise_regs u_regs (
		.phi   (phi),
		.rst   (rst),
		.wr_en (wr_en),
		.rd_en (rd_en),
		.addr  (noise_pkg::noise_reg_e'(addr)),
		.wdata (wdata),
		.rdata (rdata),
		.cfg   (cfg.regs)
	);

	frame_sequencer u_fs (
		.phi         (phi),
		.rst         (rst),
		.length_tick (length_tick),
		.env_tick    (env_tick)
	);

	noise_length u_length (
		.phi           (phi),
		.rst           (rst),
		.cfg           (cfg.core),
		.length_tick   (length_tick),
		.length_expire (length_expire)
	);

	noise_lfsr u_lfsr (
		.phi       (phi),
		.rst       (rst),
		.cfg       (cfg.core),
		.noise_bit (noise_bit)
	);

	noise_envelope u_env (
		.phi      (phi),
		.rst      (rst),
		.cfg      (cfg.core),
		.env_tick (env_tick),
		.volume   (volume)
	);

	// dac off when initial volume is 0 and direction is down
	assign dac_en = ({cfg.env.init_vol, cfg.env.dir} != 5'd0);

	always_ff @(posedge phi) begin
		if (rst)
			active_q <= 1'b0;
		else if (cfg.restart)
			active_q <= dac_en; // trigger wins over a same-cycle expiry
		else if (length_expire || !dac_en)
			active_q <= 1'b0;
	end

	assign ch4_active = active_q && dac_en; // drops at once with the dac

	always_ff @(posedge phi) begin
		if (rst)
			ch4_out <= 4'd0;
		else if (ch4_active && !noise_bit)
			ch4_out <= volume;
		else
			ch4_out <= 4'd0;
	end

endmodule

`default_nettype wire

/* verification/noise_sva.sv */
`timescale 1ns/100ps
`default_nettype none

module noise_sva (
	input logic       phi,
	input logic       rst,
	input logic       wr_en,
	input logic [1:0] addr,
	input logic [7:0] wdata,
	input logic       restart,
	input logic       ch4_active,
	input logic [3:0] ch4_out
);

	int unsigned fail_count = 0;
	logic        trig_wr;

	assign trig_wr = wr_en && (addr == noise_pkg::REG_CONTROL) && wdata[7];

	a_restart: assert property (@(posedge phi) disable iff (rst) trig_wr |=> restart)
		else begin
			fail_count++;
			$error("restart did not follow the trigger write");
		end

	// output register lags the flag by one edge
	a_quiet: assert property (@(posedge phi) disable iff (rst) !ch4_active |=> (ch4_out == 4'd0))
		else begin
			fail_count++;
			$error("ch4_out nonzero while the channel is off");
		end

	a_reset: assert property (@(posedge phi) rst |=> !ch4_active)
		else begin
			fail_count++;
			$error("ch4_active high after reset");
		end

endmodule

`default_nettype wire

/* verification/noise_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "noise_defs.svh"

module noise_tb;

	localparam int STEP = `NOISE_FS_STEP_CYCLES;
	localparam int TICK_GAP = 2 * STEP; // cycles between length ticks
	localparam int FRAME = 8 * STEP;

	typedef struct packed {
		int          cyc;
		int          step;
		logic [7:0]  env;
		logic [7:0]  poly;
		logic        len_en;
		logic        restart;
		int          len_cnt;
		int          div;
		logic [14:0] lfsr;
		int          env_cnt;
		logic [3:0]  vol;
		logic        active;
		logic [3:0]  out;
	} model_t;

	logic       phi;
	logic       rst;
	logic       wr_en;
	logic       rd_en;
	logic [1:0] addr;
	logic [7:0] wdata;
	logic [7:0] rdata;
	logic       ch4_active;
	logic       dac_en;
	logic [3:0] ch4_out;
	model_t     model;
	logic       cmp_en;
	int         errors;
	string      test_name;

	noise_channel uut (
		.phi        (phi),
		.rst        (rst),
		.wr_en      (wr_en),
		.rd_en      (rd_en),
		.addr       (addr),
		.wdata      (wdata),
		.rdata      (rdata),
		.ch4_active (ch4_active),
		.dac_en     (dac_en),
		.ch4_out    (ch4_out)
	);

	bind noise_channel noise_sva u_sva (
		.phi        (phi),
		.rst        (rst),
		.wr_en      (wr_en),
		.addr       (addr),
		.wdata      (wdata),
		.restart    (cfg.restart),
		.ch4_active (ch4_active),
		.ch4_out    (ch4_out)
	);

	function automatic logic dac_on(model_t m);
		return m.env[7:3] != 5'd0; // volume and direction bits
	endfunction

	function automatic int poly_period(logic [7:0] p);
		int base;
		base = (p[2:0] == 3'd0) ? 8 : 16 * int'(p[2:0]);
		return (base << p[7:4]) * `NOISE_DIV_SCALE;
	endfunction

	function automatic model_t model_reset();
		model_t m;
		m = '0;
		m.lfsr = '1;
		return m;
	endfunction

	// one phi edge of the whole channel
	function automatic model_t model_step(model_t s, logic wr, logic [1:0] a, logic [7:0] d);
		model_t n;
		logic   last;
		logic   expire;
		logic   fb;
		n = s;
		last = (s.cyc == STEP - 1);
		n.cyc = last ? 0 : s.cyc + 1;
		n.step = last ? (s.step + 1) % 8 : s.step;
		n.restart = wr && (a == noise_pkg::REG_CONTROL) && d[7];
		if (wr && a == noise_pkg::REG_ENVELOPE)
			n.env = d;
		if (wr && a == noise_pkg::REG_POLY)
			n.poly = d;
		if (wr && a == noise_pkg::REG_CONTROL)
			n.len_en = d[6];
		expire = 1'b0;
		if (wr && a == noise_pkg::REG_LENGTH) begin
			n.len_cnt = int'(d[5:0]);
		end else if (last && s.step % 2 == 0 && s.len_en) begin
			expire = (s.len_cnt == 63);
			n.len_cnt = (s.len_cnt + 1) % 64;
		end
		if (s.restart) begin
			n.div = poly_period(s.poly) - 1;
			n.lfsr = '1;
		end else if (s.poly[7:4] < 4'd14) begin
			if (s.div == 0) begin
				fb = s.lfsr[0] ^ s.lfsr[1];
				n.div = poly_period(s.poly) - 1;
				n.lfsr = {fb, s.lfsr[14:1]};
				if (s.poly[3])
					n.lfsr[6] = fb; // 7-bit mode
			end else begin
				n.div = s.div - 1;
			end
		end
		if (s.restart) begin
			n.env_cnt = int'(s.env[2:0]);
			n.vol = s.env[7:4];
		end else if (last && s.step == 7 && s.env[2:0] != 3'd0) begin
			n.env_cnt = (s.env_cnt <= 1) ? int'(s.env[2:0]) : s.env_cnt - 1;
			if (s.env_cnt <= 1 && s.env[3] && s.vol != 4'd15)
				n.vol = s.vol + 4'd1;
			else if (s.env_cnt <= 1 && !s.env[3] && s.vol != 4'd0)
				n.vol = s.vol - 4'd1;
		end
		if (s.restart)
			n.active = dac_on(s);
		else if (expire || !dac_on(s))
			n.active = 1'b0;
		n.out = (s.active && dac_on(s) && !s.lfsr[0]) ? s.vol : 4'd0;
		return n;
	endfunction

	task automatic stop_on_error();
		$display("Regression failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_out(input string what, input logic [3:0] exp, input logic [3:0] act);
		if (act !== exp) begin
			errors++;
			$display("FAILED %s: %s expected %h, actual %h", test_name, what, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("FAILED %s: %s expected %b, actual %b", test_name, what, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_rdata(input string what, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			errors++;
			$display("FAILED %s: %s expected %h, actual %h", test_name, what, exp, act);
			stop_on_error();
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge phi);
			#1;
		end
	endtask

	task automatic write_reg(input noise_pkg::noise_reg_e r, input logic [7:0] d);
		wr_en = 1'b1;
		addr = r;
		wdata = d;
		wait_cycles(1);
		wr_en = 1'b0;
	endtask

	task automatic read_reg(input noise_pkg::noise_reg_e r, output logic [7:0] d);
		rd_en = 1'b1;
		addr = r;
		@(negedge phi);
		d = rdata;
		wait_cycles(1);
		rd_en = 1'b0;
	endtask

	// returns once the restart pulse has been taken
	task automatic trigger(input logic len_en);
		write_reg(noise_pkg::REG_CONTROL, {1'b1, len_en, 6'd0});
		wait_cycles(1);
	endtask

	task automatic wait_inactive(input int limit, output int n);
		n = 0;
		while (ch4_active) begin
			if (n >= limit) begin
				$display("timeout in %s: ch4_active stayed high", test_name);
				stop_on_error();
			end
			wait_cycles(1);
			n++;
		end
	endtask

	task automatic wait_volume(input logic [3:0] target, input int limit);
		int n;
		n = 0;
		while (uut.u_env.volume !== target) begin
			if (n >= limit) begin
				$display("timeout in %s: volume never reached its limit", test_name);
				stop_on_error();
			end
			wait_cycles(1);
			n++;
		end
	endtask

	initial begin
		phi = 1'b0;
		forever #10 phi = ~phi;
	end

	always @(posedge phi) begin
		if (rst)
			model = model_reset();
		else
			model = model_step(model, wr_en, addr, wdata);
	end

	always @(negedge phi) begin
		if (cmp_en) begin
			check_out("ch4_out", model.out, ch4_out);
			check_flag("ch4_active", model.active && dac_on(model), ch4_active);
			check_flag("dac_en", dac_on(model), dac_en);
			if (uut.u_sva.fail_count != 0) begin
				$display("a bound assertion on the DUT failed in %s", test_name);
				stop_on_error();
			end
		end
	end

	initial begin
		logic [7:0]               rd;
		logic [5:0]               len;
		logic [3:0]               limit;
		noise_pkg::envelope_cfg_t env_cfg;
		noise_pkg::poly_cfg_t     poly_cfg;
		int                       n;
		int                       waited;
		void'($urandom(32'hae2f81a1));
		rst = 1'b1;
		wr_en = 1'b0;
		rd_en = 1'b0;
		addr = 2'd0;
		wdata = 8'h00;
		cmp_en = 1'b0;
		errors = 0;
		test_name = "reset";
		repeat (2) @(posedge phi);
		#1;
		rst = 1'b0;
		cmp_en = 1'b1;

		check_flag("ch4_active", 1'b0, ch4_active);
		check_flag("dac_en", 1'b0, dac_en);
		check_out("ch4_out", 4'd0, ch4_out);
		read_reg(noise_pkg::REG_LENGTH, rd);
		check_rdata("length", 8'hFF, rd);
		read_reg(noise_pkg::REG_ENVELOPE, rd);
		check_rdata("envelope", 8'h00, rd);
		read_reg(noise_pkg::REG_POLY, rd);
		check_rdata("poly", 8'h00, rd);
		read_reg(noise_pkg::REG_CONTROL, rd);
		check_rdata("control", 8'hBF, rd);

		test_name = "readback";
		for (n = 0; n < 8; n++) begin
			env_cfg = noise_pkg::envelope_cfg_t'(8'($urandom()));
			poly_cfg = noise_pkg::poly_cfg_t'(8'($urandom()));
			write_reg(noise_pkg::REG_ENVELOPE, env_cfg);
			write_reg(noise_pkg::REG_POLY, poly_cfg);
			write_reg(noise_pkg::REG_CONTROL, {1'b0, n[0], 6'd0});
			read_reg(noise_pkg::REG_ENVELOPE, rd);
			check_rdata("envelope", env_cfg, rd);
			read_reg(noise_pkg::REG_POLY, rd);
			check_rdata("poly", poly_cfg, rd);
			read_reg(noise_pkg::REG_CONTROL, rd);
			check_rdata("control", 8'hBF | {1'b0, n[0], 6'd0}, rd);
		end
		addr = noise_pkg::REG_ENVELOPE;
		@(negedge phi);
		check_rdata("idle bus", 8'hFF, rdata);
		wait_cycles(1);

		for (n = 0; n < 6; n++) begin
			test_name = (n < 3) ? "noise 15-bit" : "noise 7-bit";
			poly_cfg.shift = 4'($urandom_range(0, 3));
			poly_cfg.width = (n < 3) ? noise_pkg::LFSR_15 : noise_pkg::LFSR_7;
			poly_cfg.div_code = 3'($urandom_range(0, 7));
			write_reg(noise_pkg::REG_POLY, poly_cfg);
			write_reg(noise_pkg::REG_ENVELOPE, 8'hF0); // full volume, no sweep
			trigger(1'b0);
			wait_cycles(2000);
			check_flag("active after run", 1'b1, ch4_active);
		end

		for (n = 0; n < 6; n++) begin
			test_name = (n < 3) ? "envelope up" : "envelope down";
			env_cfg.init_vol = 4'($urandom_range(4, 11));
			env_cfg.dir = (n < 3) ? noise_pkg::ENV_UP : noise_pkg::ENV_DOWN;
			env_cfg.period = 3'(n % 3 + 1);
			limit = (n < 3) ? 4'd15 : 4'd0;
			write_reg(noise_pkg::REG_POLY, 8'h00);
			write_reg(noise_pkg::REG_ENVELOPE, env_cfg);
			trigger(1'b0);
			wait_volume(limit, 16 * FRAME * 8);
			wait_cycles(3 * FRAME * int'(env_cfg.period));
			check_out("volume held", limit, uut.u_env.volume);
		end

		test_name = "length enabled";
		write_reg(noise_pkg::REG_ENVELOPE, 8'hF0);
		for (n = 0; n < 3; n++) begin
			len = 6'($urandom_range(0, 63));
			write_reg(noise_pkg::REG_LENGTH, {2'b00, len});
			trigger(1'b1);
			check_flag("active after trigger", 1'b1, ch4_active);
			wait_inactive((66 - model.len_cnt) * TICK_GAP, waited);
			check_flag("model expiry", 1'b0, model.active);
		end
		test_name = "length retrigger";
		trigger(1'b1);
		wait_inactive(66 * TICK_GAP, waited);
		check_flag("full 64 ticks", 1'b1, waited >= 63 * TICK_GAP);

		test_name = "length disabled";
		write_reg(noise_pkg::REG_LENGTH, 8'd60);
		trigger(1'b0);
		wait_cycles(10 * TICK_GAP);
		check_flag("still active", 1'b1, ch4_active);

		test_name = "dac off";
		write_reg(noise_pkg::REG_ENVELOPE, 8'h05); // volume 0, down
		check_flag("dac_en", 1'b0, dac_en);
		check_flag("ch4_active", 1'b0, ch4_active);
		trigger(1'b0);
		wait_cycles(4 * STEP);
		check_flag("active after trigger", 1'b0, ch4_active);

		if (errors == 0) begin
			$display("Regression passed");
			$finish;
		end else begin
			stop_on_error();
		end
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+common
common/noise_pkg.sv
common/noise_cfg_if.sv
design/noise_regs.sv
design/frame_sequencer.sv
design/noise_length.sv
design/noise_lfsr.sv
design/noise_envelope.sv
design/noise_channel.sv
verification/noise_sva.sv
verification/noise_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = noise_tb
FILELIST = src.f
OBJDIR   = obj_dir
RUNARGS  = +verilator+error+limit+100

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) $(RUNARGS)

clean:
	rm -rf $(OBJDIR)
